//--- Bender.yml
package:
  name: io_ctrl

sources:
  - files:
      - io_ctrl_pkg.sv
      - serial_cfg_pkg.sv
      - iomem_if.sv
      - loader_if.sv
      - io_ctrl_wb.sv
      - io_ctrl_regs.sv
      - io_serial_loader.sv
      - pad_config_chain.sv
      - io_ctrl_top.sv
  - target: test
    files:
      - io_ctrl_sva.sv
      - tb_io_ctrl_top.sv

//--- io_ctrl_pkg.sv
`default_nettype none

package io_ctrl_pkg;

    // Bus widths shared by Wishbone and the internal memory port
    localparam int BUS_AW = 32;
    localparam int BUS_DW = 32;

    // Register map, byte offsets inside the 256-byte window
    localparam logic [7:0] XFER_OFS   = 8'h00;  // Transfer start / busy
    localparam logic [7:0] PWR_OFS    = 8'h04;  // Power control word
    localparam logic [7:0] IODATA_OFS = 8'h08;  // GPIO data, all pads in one word
    localparam logic [7:0] IOCFG_OFS  = 8'h20;  // Pad 0 config, pad i at +4*i

    // Pad configuration at reset
    localparam logic [BUS_DW-1:0] CFG_BIDIR_DEFAULT = 32'h0000_1803;  // Bidirectional pad
    localparam logic [BUS_DW-1:0] CFG_INPUT_DEFAULT = 32'h0000_0403;  // Plain input pad

    // Pads 0 and 1 carry JTAG and SDO, so they come up bidirectional
    function automatic logic [BUS_DW-1:0] cfg_default(int pad);
        logic [BUS_DW-1:0] word;
        word = (pad < 2) ? CFG_BIDIR_DEFAULT : CFG_INPUT_DEFAULT;
        return word;
    endfunction

endpackage

`default_nettype wire

//--- io_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_regs import io_ctrl_pkg::*, serial_cfg_pkg::*; #(
    parameter logic [BUS_AW-1:0] BASE_ADR = 32'h2300_0000,
    parameter int                NUM_PADS = 8,
    parameter int                CFG_BITS = 13,
    parameter int                PWR_PADS = 4
) (
    input  logic                clk,
    input  logic                resetn,
    iomem_if.slave              mem,
    loader_if.ctrl              ld,
    input  logic [NUM_PADS-1:0] mgmt_gpio_in_i,
    output logic [NUM_PADS-1:0] mgmt_gpio_out_o,
    output logic [NUM_PADS-1:0] mgmt_gpio_oeb_o,
    output logic [PWR_PADS-1:0] pwr_ctrl_o,
    output logic                jtag_oenb_state_o,
    output logic                sdo_oenb_state_o
);

    logic [CFG_BITS-1:0] io_cfg [NUM_PADS];  // One word per pad
    logic [NUM_PADS-1:0] gpio_out_q;
    logic [PWR_PADS-1:0] pwr_q;
    logic [BUS_DW-1:0]   rdata_pre;
    logic [7:0]          ofs;
    logic                hit;
    logic                acc;
    logic                wr_en;

    assign ofs   = mem.addr[7:0];
    assign hit   = (mem.addr[BUS_AW-1:8] == BASE_ADR[BUS_AW-1:8]);
    assign acc   = mem.valid & ~mem.ready;   // First cycle of an access
    assign wr_en = acc & hit & mem.wstrb[0]; // Byte writes are ignored

    // Read mux, zero for unmapped offsets
    always_comb begin
        rdata_pre = '0;
        case (ofs)
            XFER_OFS:   rdata_pre = BUS_DW'(ld.busy);
            PWR_OFS:    rdata_pre = BUS_DW'(pwr_q);
            IODATA_OFS: rdata_pre = BUS_DW'(mgmt_gpio_in_i);
            default:    ;
        endcase
        for (int i = 0; i < NUM_PADS; i++) begin
            if (ofs == IOCFG_OFS + 8'(4 * i)) begin
                rdata_pre = BUS_DW'(io_cfg[i]);
            end
        end
    end

    // Every access is acked, also outside the window
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mem.ready <= 1'b0;
            ld.start  <= 1'b0;
        end else begin
            mem.ready <= acc;
            ld.start  <= wr_en & (ofs == XFER_OFS) & mem.wdata[0];  // Self-clearing
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            mem.rdata <= hit ? rdata_pre : '0;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pwr_q      <= '0;
            gpio_out_q <= '0;
        end else if (wr_en) begin
            if (ofs == PWR_OFS) begin
                pwr_q <= mem.wdata[PWR_PADS-1:0];
            end
            if (ofs == IODATA_OFS) begin
                gpio_out_q <= mem.wdata[NUM_PADS-1:0];
            end
        end
    end

    // Pad configuration words
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_PADS; i++) begin
                io_cfg[i] <= CFG_BITS'(cfg_default(i));
            end
        end else if (wr_en) begin
            for (int i = 0; i < NUM_PADS; i++) begin
                if (ofs == IOCFG_OFS + 8'(4 * i)) begin
                    io_cfg[i] <= mem.wdata[CFG_BITS-1:0];
                end
            end
        end
    end

    assign ld.pad_word = io_cfg[ld.pad_sel];  // Loader fetch port

    for (genvar i = 0; i < NUM_PADS; i++) begin : g_oeb
        // Input disabled means the management side drives the pad
        assign mgmt_gpio_oeb_o[i] = ~io_cfg[i][CFG_INP_DIS_BIT];
    end

    assign mgmt_gpio_out_o = gpio_out_q;
    assign pwr_ctrl_o      = pwr_q;

    // Tell the core when JTAG or SDO pads have been turned into outputs
    assign jtag_oenb_state_o = io_cfg[0][CFG_OEB_BIT];
    assign sdo_oenb_state_o  = io_cfg[1][CFG_OEB_BIT];

endmodule

`default_nettype wire

//--- io_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_sva (
    input logic clk,
    input logic resetn,
    input logic ack_i,
    input logic busy_i,
    input logic serial_clock_i,
    input logic serial_data_i,
    input logic serial_load_i
);

    int   err_cnt = 0;  // Failed assertion count read by the testbench
    logic load_seen;    // Load strobe seen during the current transfer

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            load_seen <= 1'b0;
        end else if (!busy_i) begin
            load_seen <= 1'b0;
        end else if (serial_load_i) begin
            load_seen <= 1'b1;
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (!resetn) ack_i |=> !ack_i)
        else begin $error("Wishbone ack high in two consecutive cycles"); err_cnt++; end

    load_in_busy: assert property (@(posedge clk) disable iff (!resetn)
        $rose(serial_load_i) |-> busy_i)
        else begin $error("serial_load rose while the loader was idle"); err_cnt++; end

    // Data may only move while the serial clock is low
    data_stable: assert property (@(posedge clk) disable iff (!resetn)
        $changed(serial_data_i) |-> !serial_clock_i)
        else begin $error("serial_data changed while serial_clock was high"); err_cnt++; end

    busy_end: assert property (@(posedge clk) disable iff (!resetn) $fell(busy_i) |-> load_seen)
        else begin $error("busy fell without a serial_load pulse"); err_cnt++; end

endmodule

bind io_ctrl_top io_ctrl_sva u_sva (
    .clk            (clk),
    .resetn         (resetn),
    .ack_i          (wb_ack_o),
    .busy_i         (ld_bus.busy),
    .serial_clock_i (serial_clock),
    .serial_data_i  (serial_data),
    .serial_load_i  (serial_load)
);

`default_nettype wire

//--- io_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_top import io_ctrl_pkg::*; #(
    parameter logic [BUS_AW-1:0] BASE_ADR = 32'h2300_0000,
    parameter int                NUM_PADS = 8,   // Up to 32
    parameter int                CFG_BITS = 13,
    parameter int                PWR_PADS = 4
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic [BUS_AW-1:0]            wb_adr_i,
    input  logic [BUS_DW-1:0]            wb_dat_i,
    input  logic [3:0]                   wb_sel_i,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    output logic [BUS_DW-1:0]            wb_dat_o,
    output logic                         wb_ack_o,
    input  logic [NUM_PADS-1:0]          mgmt_gpio_in_i,
    output logic [NUM_PADS-1:0]          mgmt_gpio_out_o,
    output logic [NUM_PADS-1:0]          mgmt_gpio_oeb_o,
    output logic [PWR_PADS-1:0]          pwr_ctrl_o,
    output logic                         jtag_oenb_state_o,
    output logic                         sdo_oenb_state_o,
    output logic [NUM_PADS*CFG_BITS-1:0] pad_cfg_o
);

    logic serial_clock;
    logic serial_data;
    logic serial_load;

    iomem_if mem_bus ();
    loader_if #(.NUM_PADS(NUM_PADS), .CFG_BITS(CFG_BITS)) ld_bus ();

    io_ctrl_wb u_wb (
        .clk      (clk),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .mem      (mem_bus.master)
    );

    io_ctrl_regs #(
        .BASE_ADR (BASE_ADR),
        .NUM_PADS (NUM_PADS),
        .CFG_BITS (CFG_BITS),
        .PWR_PADS (PWR_PADS)
    ) u_regs (
        .clk               (clk),
        .resetn            (resetn),
        .mem               (mem_bus.slave),
        .ld                (ld_bus.ctrl),
        .mgmt_gpio_in_i    (mgmt_gpio_in_i),
        .mgmt_gpio_out_o   (mgmt_gpio_out_o),
        .mgmt_gpio_oeb_o   (mgmt_gpio_oeb_o),
        .pwr_ctrl_o        (pwr_ctrl_o),
        .jtag_oenb_state_o (jtag_oenb_state_o),
        .sdo_oenb_state_o  (sdo_oenb_state_o)
    );

    io_serial_loader #(
        .NUM_PADS (NUM_PADS),
        .CFG_BITS (CFG_BITS)
    ) u_loader (
        .clk            (clk),
        .resetn         (resetn),
        .ld             (ld_bus.loader),
        .serial_clock_o (serial_clock),
        .serial_data_o  (serial_data),
        .serial_load_o  (serial_load)
    );

    // Pad-side model of the configuration shift chain
    pad_config_chain #(
        .NUM_PADS (NUM_PADS),
        .CFG_BITS (CFG_BITS)
    ) u_chain (
        .clk            (clk),
        .resetn         (resetn),
        .serial_clock_i (serial_clock),
        .serial_data_i  (serial_data),
        .serial_load_i  (serial_load),
        .pad_cfg_o      (pad_cfg_o)
    );

endmodule

`default_nettype wire

//--- io_ctrl_wb.sv
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_wb import io_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic [BUS_AW-1:0] wb_adr_i,
    input  logic [BUS_DW-1:0] wb_dat_i,
    input  logic [3:0]        wb_sel_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    output logic [BUS_DW-1:0] wb_dat_o,
    output logic              wb_ack_o,
    iomem_if.master           mem
);

    logic ack_cyc;  // High while the ack of the last access is on the bus

    // A still-asserted stb in the ack cycle is the same access, not a new one
    assign mem.valid = wb_cyc_i & wb_stb_i & ~ack_cyc;
    assign mem.addr  = wb_adr_i;
    assign mem.wdata = wb_dat_i;
    assign mem.wstrb = wb_sel_i[1:0] & {2{wb_we_i}};  // Upper lanes never write

    assign wb_dat_o = mem.rdata;
    assign wb_ack_o = mem.ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_cyc <= 1'b0;
        end else begin
            ack_cyc <= mem.valid;
        end
    end

endmodule

`default_nettype wire

//--- io_serial_loader.sv
`timescale 1ns/1ps
`default_nettype none

module io_serial_loader import serial_cfg_pkg::*; #(
    parameter int NUM_PADS = 8,
    parameter int CFG_BITS = 13
) (
    input  logic     clk,
    input  logic     resetn,
    loader_if.loader ld,
    output logic     serial_clock_o,
    output logic     serial_data_o,
    output logic     serial_load_o
);

    localparam int PAD_W = pad_idx_w(NUM_PADS);
    localparam int BIT_W = (CFG_BITS > 4) ? $clog2(CFG_BITS) : 2;  // Also counts load steps

    loader_state_e       state;
    logic [PAD_W-1:0]    pad_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic [CFG_BITS-1:0] stage;
    logic                last_bit;

    assign ld.busy       = (state != LD_IDLE);
    assign ld.pad_sel    = pad_cnt;
    assign serial_data_o = stage[CFG_BITS-1];  // MSB first
    assign last_bit      = (bit_cnt == BIT_W'(CFG_BITS - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state          <= LD_IDLE;
            pad_cnt        <= PAD_W'(NUM_PADS - 1);
            bit_cnt        <= '0;
            stage          <= '0;
            serial_clock_o <= 1'b0;
            serial_load_o  <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    serial_clock_o <= 1'b0;
                    pad_cnt        <= PAD_W'(NUM_PADS - 1);  // Highest pad goes first
                    if (ld.start) begin
                        state <= LD_START;
                    end
                end
                LD_START: begin
                    stage   <= ld.pad_word;
                    bit_cnt <= '0;
                    state   <= LD_SHIFT;
                end
                LD_SHIFT: begin
                    serial_clock_o <= ~serial_clock_o;
                    // End of a high phase, bit has been taken by the chain
                    if (serial_clock_o) begin
                        if (!last_bit) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            stage   <= {stage[CFG_BITS-2:0], 1'b0};
                        end else if (pad_cnt == '0) begin
                            state          <= LD_LOAD;
                            bit_cnt        <= '0;
                            serial_clock_o <= 1'b1;  // Stay high, no extra shift edge
                        end else begin
                            pad_cnt <= pad_cnt - 1'b1;
                            state   <= LD_START;
                        end
                    end
                end
                LD_LOAD: begin
                    // Clock high for three cycles, strobe in the middle one
                    bit_cnt       <= bit_cnt + 1'b1;
                    serial_load_o <= (bit_cnt == BIT_W'(0));
                    if (bit_cnt == BIT_W'(2)) begin
                        serial_clock_o <= 1'b0;
                    end
                    if (bit_cnt == BIT_W'(3)) begin
                        state <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- iomem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface iomem_if import io_ctrl_pkg::*; ();

    logic [BUS_AW-1:0] addr;
    logic              valid;   // Held until ready
    logic [1:0]        wstrb;   // Only bit 0 enables a register write
    logic [BUS_DW-1:0] wdata;
    logic [BUS_DW-1:0] rdata;   // Valid together with ready
    logic              ready;   // One-cycle pulse

    modport master (
        output addr, valid, wstrb, wdata,
        input  rdata, ready
    );

    modport slave (
        input  addr, valid, wstrb, wdata,
        output rdata, ready
    );

endinterface

`default_nettype wire

//--- loader_if.sv
`timescale 1ns/1ps
`default_nettype none

interface loader_if import serial_cfg_pkg::*; #(
    parameter int NUM_PADS = 8,
    parameter int CFG_BITS = 13
) ();

    logic                           start;     // One-cycle request from the register file
    logic                           busy;
    logic [pad_idx_w(NUM_PADS)-1:0] pad_sel;   // Pad whose word the loader wants
    logic [CFG_BITS-1:0]            pad_word;  // Returned combinationally

    modport ctrl   (output start, pad_word, input busy, pad_sel);
    modport loader (input start, pad_word, output busy, pad_sel);

endinterface

`default_nettype wire

//--- pad_config_chain.sv
`timescale 1ns/1ps
`default_nettype none

module pad_config_chain import io_ctrl_pkg::*; #(
    parameter int NUM_PADS = 8,
    parameter int CFG_BITS = 13
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         serial_clock_i,
    input  logic                         serial_data_i,
    input  logic                         serial_load_i,
    output logic [NUM_PADS*CFG_BITS-1:0] pad_cfg_o
);

    logic [NUM_PADS-1:0][CFG_BITS-1:0] stage;   // Shift stages
    logic [NUM_PADS-1:0][CFG_BITS-1:0] shadow;  // Active pad configuration
    logic [NUM_PADS-1:0]               link;    // Serial input of each stage
    logic                              sclk_q;
    logic                              load_q;
    logic                              sclk_rise;

    assign sclk_rise = serial_clock_i & ~sclk_q;
    assign link[0]   = serial_data_i;           // Chain enters at pad 0

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sclk_q <= 1'b0;
            load_q <= 1'b0;
        end else begin
            sclk_q <= serial_clock_i;
            load_q <= serial_load_i;
        end
    end

    for (genvar i = 1; i < NUM_PADS; i++) begin : g_link
        assign link[i] = stage[i-1][CFG_BITS-1];  // Overflow into the next pad up
    end

    for (genvar i = 0; i < NUM_PADS; i++) begin : g_pad
        always_ff @(posedge clk) begin
            if (sclk_rise) begin
                stage[i] <= {stage[i][CFG_BITS-2:0], link[i]};
            end
        end

        always_ff @(posedge clk or negedge resetn) begin
            if (!resetn) begin
                shadow[i] <= CFG_BITS'(cfg_default(i));
            end else if (load_q) begin
                shadow[i] <= stage[i];
            end
        end
    end

    assign pad_cfg_o = shadow;

endmodule

`default_nettype wire

//--- serial_cfg_pkg.sv
`default_nettype none

package serial_cfg_pkg;

    // Serial loader states
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_START,   // Fetch next pad word
        LD_SHIFT,   // Clock bits out, MSB first
        LD_LOAD     // Strobe the chain into the shadow registers
    } loader_state_e;

    // Bit positions inside a pad configuration word
    localparam int CFG_OEB_BIT     = 1;
    localparam int CFG_INP_DIS_BIT = 3;

    // Width of a pad index, never below one bit
    function automatic int pad_idx_w(int num_pads);
        int w;
        w = (num_pads > 1) ? $clog2(num_pads) : 1;
        return w;
    endfunction

endpackage

`default_nettype wire

//--- tb.f
io_ctrl_pkg.sv
serial_cfg_pkg.sv
iomem_if.sv
loader_if.sv
io_ctrl_wb.sv
io_ctrl_regs.sv
io_serial_loader.sv
pad_config_chain.sv
io_ctrl_top.sv
io_ctrl_sva.sv
tb_io_ctrl_top.sv

//--- tb_io_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_io_ctrl_top;

    localparam int          NUM_PADS    = 8;
    localparam int          CFG_BITS    = 13;
    localparam logic [31:0] BASE        = 32'h2300_0000;
    localparam int          LOAD_CYCLES = NUM_PADS * (1 + 2 * CFG_BITS) + 4;
    localparam int          MAX_CYCLES  = 3 * LOAD_CYCLES + 2340;  // Plus all bus traffic

    logic                         clk;
    logic                         resetn;
    logic [31:0]                  wb_adr;
    logic [31:0]                  wb_dat_w;
    logic [3:0]                   wb_sel;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [31:0]                  wb_dat_r;
    logic                         wb_ack;
    logic [NUM_PADS-1:0]          gpio_in;
    logic [NUM_PADS-1:0]          gpio_out;
    logic [NUM_PADS-1:0]          gpio_oeb;
    logic [3:0]                   pwr;
    logic                         jtag_oenb;
    logic                         sdo_oenb;
    logic [NUM_PADS*CFG_BITS-1:0] pad_cfg;

    int                  seed = 32'h44af;
    int                  errors = 0;
    int                  err_mark = 0;
    int                  tests_ok = 0;
    int                  tests_bad = 0;
    int                  cycles = 0;
    logic [CFG_BITS-1:0] cfg_ref [NUM_PADS];     // Register file words
    logic [CFG_BITS-1:0] shadow_ref [NUM_PADS];  // Words active at the pads
    logic [3:0]          pwr_ref;
    logic [31:0]         rd;
    logic [31:0]         val;

    io_ctrl_top dut (
        .clk               (clk),
        .resetn            (resetn),
        .wb_adr_i          (wb_adr),
        .wb_dat_i          (wb_dat_w),
        .wb_sel_i          (wb_sel),
        .wb_cyc_i          (wb_cyc),
        .wb_stb_i          (wb_stb),
        .wb_we_i           (wb_we),
        .wb_dat_o          (wb_dat_r),
        .wb_ack_o          (wb_ack),
        .mgmt_gpio_in_i    (gpio_in),
        .mgmt_gpio_out_o   (gpio_out),
        .mgmt_gpio_oeb_o   (gpio_oeb),
        .pwr_ctrl_o        (pwr),
        .jtag_oenb_state_o (jtag_oenb),
        .sdo_oenb_state_o  (sdo_oenb),
        .pad_cfg_o         (pad_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One Wishbone access, inputs change and ack is sampled on the falling edge
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] data);
        @(negedge clk);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        do @(negedge clk); while (!wb_ack);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%s: passed", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    function automatic logic [31:0] cfg_addr(int pad);
        return BASE + 32'h20 + 32'(4 * pad);
    endfunction

    function automatic logic [31:0] pad_slice(int pad);
        return 32'(pad_cfg[pad*CFG_BITS +: CFG_BITS]);
    endfunction

    initial begin
        resetn   = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        gpio_in  = '0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;

        // Pads 0 and 1 bidirectional, the rest inputs
        for (int i = 0; i < NUM_PADS; i++) begin
            cfg_ref[i]    = (i < 2) ? 13'h1803 : 13'h0403;
            shadow_ref[i] = cfg_ref[i];
            bus_access(1'b0, cfg_addr(i), 32'h0, 4'hf, rd);
            check_val($sformatf("cfg[%0d]", i), 32'(cfg_ref[i]), rd);
            check_val($sformatf("pad_cfg_o[%0d]", i), 32'(shadow_ref[i]), pad_slice(i));
        end
        check_val("jtag_oenb_state_o", 32'h1, 32'(jtag_oenb));
        check_val("sdo_oenb_state_o", 32'h1, 32'(sdo_oenb));
        report_test("reset defaults");

        for (int i = 0; i < NUM_PADS; i++) begin
            val        = 32'($random(seed));
            cfg_ref[i] = val[CFG_BITS-1:0];
            bus_access(1'b1, cfg_addr(i), val, 4'hf, rd);
        end
        bus_access(1'b1, cfg_addr(2), ~val, 4'he, rd);  // Lane 0 off, no write
        for (int i = 0; i < NUM_PADS; i++) begin
            bus_access(1'b0, cfg_addr(i), 32'h0, 4'hf, rd);
            check_val($sformatf("cfg[%0d]", i), 32'(cfg_ref[i]), rd);
            check_val($sformatf("pad_cfg_o[%0d]", i), 32'(shadow_ref[i]), pad_slice(i));
        end
        report_test("config write and readback");

        val     = 32'($random(seed));
        pwr_ref = val[3:0];
        bus_access(1'b1, BASE + 32'h4, val, 4'hf, rd);
        check_val("pwr_ctrl_o", 32'(pwr_ref), 32'(pwr));
        bus_access(1'b0, BASE + 32'h4, 32'h0, 4'hf, rd);
        check_val("pwr readback", 32'(pwr_ref), rd);
        val = 32'($random(seed));
        bus_access(1'b1, BASE + 32'h8, val, 4'hf, rd);
        check_val("mgmt_gpio_out_o", 32'(val[NUM_PADS-1:0]), 32'(gpio_out));
        for (int i = 0; i < NUM_PADS; i++) begin
            check_val($sformatf("mgmt_gpio_oeb_o[%0d]", i), 32'(!cfg_ref[i][3]), 32'(gpio_oeb[i]));
        end
        @(negedge clk);
        gpio_in = NUM_PADS'($random(seed));
        bus_access(1'b0, BASE + 32'h8, 32'h0, 4'hf, rd);
        check_val("gpio input readback", 32'(gpio_in), rd);
        report_test("power and gpio data");

        for (int i = 0; i < NUM_PADS; i++) begin
            shadow_ref[i] = cfg_ref[i];
        end
        bus_access(1'b1, BASE, 32'h1, 4'hf, rd);
        bus_access(1'b0, BASE, 32'h0, 4'hf, rd);
        check_val("busy after start", 32'h1, rd);
        // Highest pad is already latched, pad 0 is fetched last
        val                 = 32'($random(seed));
        cfg_ref[NUM_PADS-1] = val[CFG_BITS-1:0];
        bus_access(1'b1, cfg_addr(NUM_PADS - 1), val, 4'hf, rd);
        val           = 32'($random(seed));
        cfg_ref[0]    = val[CFG_BITS-1:0];
        shadow_ref[0] = cfg_ref[0];
        bus_access(1'b1, cfg_addr(0), val, 4'hf, rd);
        do begin
            bus_access(1'b0, BASE, 32'h0, 4'hf, rd);
        end while (rd[0]);
        for (int i = 0; i < NUM_PADS; i++) begin
            check_val($sformatf("pad_cfg_o[%0d]", i), 32'(shadow_ref[i]), pad_slice(i));
        end
        check_val("jtag_oenb_state_o", 32'(cfg_ref[0][1]), 32'(jtag_oenb));
        check_val("sdo_oenb_state_o", 32'(cfg_ref[1][1]), 32'(sdo_oenb));
        report_test("serial load");

        val = 32'($random(seed));
        bus_access(1'b0, BASE + 32'h0c, 32'h0, 4'hf, rd);
        check_val("read at 0x0c", 32'h0, rd);
        bus_access(1'b0, cfg_addr(NUM_PADS), 32'h0, 4'hf, rd);
        check_val("read past last pad", 32'h0, rd);
        bus_access(1'b0, BASE + 32'h120, 32'h0, 4'hf, rd);  // Outside the window
        check_val("read outside window", 32'h0, rd);
        bus_access(1'b1, BASE + 32'h120, val, 4'hf, rd);
        bus_access(1'b1, BASE + 32'h104, val, 4'hf, rd);
        bus_access(1'b1, BASE + 32'h0c, val, 4'hf, rd);
        bus_access(1'b0, cfg_addr(0), 32'h0, 4'hf, rd);
        check_val("cfg[0]", 32'(cfg_ref[0]), rd);
        bus_access(1'b0, BASE + 32'h4, 32'h0, 4'hf, rd);
        check_val("pwr readback", 32'(pwr_ref), rd);
        report_test("unmapped access");

        if (dut.u_sva.err_cnt != 0) begin
            $display("Concurrent assertions failed %0d times", dut.u_sva.err_cnt);
            errors++;
        end
        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
